// File: source/axil_sram_pkg.sv
`default_nettype none

package axil_sram_pkg;

  ////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////

  localparam int AXIL_ADDR_WIDTH = 20;                    // Byte address
  localparam int AXIL_DATA_WIDTH = 16;
  localparam int STRB_WIDTH      = AXIL_DATA_WIDTH / 8;   // One strobe per byte lane
  localparam int ADDR_LSB        = $clog2(STRB_WIDTH);    // Byte offset bits
  localparam int WORD_ADDR_WIDTH = AXIL_ADDR_WIDTH - ADDR_LSB;

  ////////////////////////////////////////////////////////////
  // Storage sizes
  ////////////////////////////////////////////////////////////

  localparam int SRAM_ADDR_WIDTH = 8;                     // 256 words decoded
  localparam int FIFO_DEPTH      = 4;
  localparam int FIFO_PTR_WIDTH  = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH  = $clog2(FIFO_DEPTH + 1); // Holds 0..FIFO_DEPTH

  ////////////////////////////////////////////////////////////
  // SRAM word
  ////////////////////////////////////////////////////////////

  // Same 16 bits, addressed as one word or per byte lane
  typedef union packed {
    logic [AXIL_DATA_WIDTH-1:0]     word;
    logic [STRB_WIDTH-1:0][7:0]     lanes;  // lanes[0] is the low byte
  } sram_word_t;

endpackage

`default_nettype wire

// File: source/axil_wr_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module axil_wr_adapter (
  input  logic                                       clk,
  input  logic                                       rst_n,

  input  logic [axil_sram_pkg::AXIL_ADDR_WIDTH-1:0]  awaddr,
  input  logic                                       awvalid,
  output logic                                       awready,

  input  logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0]  wdata,
  input  logic [axil_sram_pkg::STRB_WIDTH-1:0]       wstrb,
  input  logic                                       wvalid,
  output logic                                       wready,

  output logic [1:0]                                 bresp,
  output logic                                       bvalid,
  input  logic                                       bready,

  output logic                                       cmd_valid,
  input  logic                                       cmd_ready,
  output logic [axil_sram_pkg::WORD_ADDR_WIDTH-1:0]  cmd_addr,
  output logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0]  cmd_data,
  output logic [axil_sram_pkg::STRB_WIDTH-1:0]       cmd_strb
);
  import axil_sram_pkg::*;

  logic                       aw_lat_valid;
  logic [WORD_ADDR_WIDTH-1:0] aw_lat_addr;
  logic                       w_lat_valid;
  logic [AXIL_DATA_WIDTH-1:0] w_lat_data;
  logic [STRB_WIDTH-1:0]      w_lat_strb;

  logic                       aw_present;
  logic                       w_present;
  logic                       aw_fire;
  logic                       w_fire;
  logic                       cmd_fire;
  logic                       cmd_stall;

  ////////////////////////////////////////////////////////////
  // Channel join
  ////////////////////////////////////////////////////////////

  assign aw_present = aw_lat_valid | awvalid;
  assign w_present  = w_lat_valid | wvalid;

  // Only one write in flight, so nothing issues while B waits
  assign cmd_valid = aw_present & w_present & ~bvalid;
  assign cmd_fire  = cmd_valid & cmd_ready;
  assign cmd_stall = cmd_valid & ~cmd_ready;

  // A live channel is taken only when it can go straight out or into its latch
  assign awready = awvalid & ~aw_lat_valid & ~bvalid & ~cmd_stall;
  assign wready  = wvalid & ~w_lat_valid & ~bvalid & ~cmd_stall;

  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;

  assign cmd_addr = aw_lat_valid ? aw_lat_addr : awaddr[AXIL_ADDR_WIDTH-1:ADDR_LSB];
  assign cmd_data = w_lat_valid ? w_lat_data : wdata;
  assign cmd_strb = w_lat_valid ? w_lat_strb : wstrb;

  assign bresp = 2'b00;  // Always OKAY

  ////////////////////////////////////////////////////////////
  // Latches and response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_lat_valid <= 1'b0;
      w_lat_valid  <= 1'b0;
      bvalid       <= 1'b0;
    end else begin
      if (cmd_fire) begin
        aw_lat_valid <= 1'b0;
      end else if (aw_fire) begin
        aw_lat_valid <= 1'b1;  // Lone AW, wait for W
      end

      if (cmd_fire) begin
        w_lat_valid <= 1'b0;
      end else if (w_fire) begin
        w_lat_valid <= 1'b1;   // Lone W, wait for AW
      end

      if (cmd_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_lat_addr <= awaddr[AXIL_ADDR_WIDTH-1:ADDR_LSB];
    end
    if (w_fire) begin
      w_lat_data <= wdata;
      w_lat_strb <= wstrb;
    end
  end

  // Stalled command keeps its payload, latched or held by the master
  cmd_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    cmd_stall |=> cmd_valid && $stable(cmd_addr) && $stable(cmd_data)
                  && $stable(cmd_strb));

endmodule

`default_nettype wire

// File: source/wr_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module wr_cmd_fifo (
  input  logic                                       clk,
  input  logic                                       rst_n,

  input  logic                                       in_valid,
  output logic                                       in_ready,
  input  logic [axil_sram_pkg::WORD_ADDR_WIDTH-1:0]  in_addr,
  input  logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0]  in_data,
  input  logic [axil_sram_pkg::STRB_WIDTH-1:0]       in_strb,

  output logic                                       out_valid,
  input  logic                                       out_ready,
  output logic [axil_sram_pkg::WORD_ADDR_WIDTH-1:0]  out_addr,
  output logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0]  out_data,
  output logic [axil_sram_pkg::STRB_WIDTH-1:0]       out_strb,

  output logic                                       busy
);
  import axil_sram_pkg::*;

  logic [WORD_ADDR_WIDTH-1:0] addr_mem [FIFO_DEPTH];
  logic [AXIL_DATA_WIDTH-1:0] data_mem [FIFO_DEPTH];
  logic [STRB_WIDTH-1:0]      strb_mem [FIFO_DEPTH];

  logic [FIFO_PTR_WIDTH-1:0]  wr_ptr;
  logic [FIFO_PTR_WIDTH-1:0]  rd_ptr;
  logic [FIFO_CNT_WIDTH-1:0]  count;
  logic                       push;
  logic                       pop;

  assign in_ready  = (count != FIFO_CNT_WIDTH'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign busy      = out_valid;     // Writes still queued
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  assign out_addr = addr_mem[rd_ptr];
  assign out_data = data_mem[rd_ptr];
  assign out_strb = strb_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr] <= in_addr;
      data_mem[wr_ptr] <= in_data;
      strb_mem[wr_ptr] <= in_strb;
    end
  end

  // Full FIFO keeps its oldest entry until it is popped
  no_push_full_a : assert property (@(posedge clk) disable iff (!rst_n)
    count == FIFO_CNT_WIDTH'(FIFO_DEPTH) && !out_ready |=> out_valid
      && $stable(out_addr) && $stable(out_data) && $stable(out_strb));

  // Empty FIFO shows nothing until something is pushed
  no_pop_empty_a : assert property (@(posedge clk) disable iff (!rst_n)
    count == '0 && !in_valid |=> !out_valid);

endmodule

`default_nettype wire

// File: source/byte_lane_sram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_sram (
  input  logic                                       clk,
  input  logic                                       hold,

  input  logic                                       wr_valid,
  output logic                                       wr_ready,
  input  logic [axil_sram_pkg::WORD_ADDR_WIDTH-1:0]  wr_addr,
  input  logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0]  wr_data,
  input  logic [axil_sram_pkg::STRB_WIDTH-1:0]       wr_strb,

  input  logic                                       rd_en,
  input  logic [axil_sram_pkg::SRAM_ADDR_WIDTH-1:0]  rd_addr,
  output axil_sram_pkg::sram_word_t                  rd_data
);
  import axil_sram_pkg::*;

  sram_word_t                 mem [2**SRAM_ADDR_WIDTH];

  logic [SRAM_ADDR_WIDTH-1:0] wr_idx;
  logic                       wr_fire;
  sram_word_t                 wr_word;
  sram_word_t                 cur_word;
  sram_word_t                 merged;

  assign wr_ready = ~hold;
  assign wr_fire  = wr_valid & wr_ready;
  assign wr_idx   = wr_addr[SRAM_ADDR_WIDTH-1:0];  // Upper word bits alias

  ////////////////////////////////////////////////////////////
  // Byte lane merge
  ////////////////////////////////////////////////////////////

  always_comb begin
    wr_word.word = wr_data;
    cur_word     = mem[wr_idx];
    for (int i = 0; i < STRB_WIDTH; i++) begin
      merged.lanes[i] = wr_strb[i] ? wr_word.lanes[i] : cur_word.lanes[i];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_idx] <= merged;
    end
  end

  // Old contents on a same-cycle write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // A write held off by hold is still pending with the same payload
  hold_no_write_a : assert property (@(posedge clk)
    wr_valid && hold |=> wr_valid && $stable(wr_addr) && $stable(wr_data)
                         && $stable(wr_strb));

endmodule

`default_nettype wire

// File: source/axil_sram_top.sv
`timescale 1ns/1ps
`default_nettype none

module axil_sram_top (
  input  logic                                       clk,
  input  logic                                       rst_n,

  input  logic [axil_sram_pkg::AXIL_ADDR_WIDTH-1:0]  awaddr,
  input  logic                                       awvalid,
  output logic                                       awready,
  input  logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0]  wdata,
  input  logic [axil_sram_pkg::STRB_WIDTH-1:0]       wstrb,
  input  logic                                       wvalid,
  output logic                                       wready,
  output logic [1:0]                                 bresp,
  output logic                                       bvalid,
  input  logic                                       bready,

  input  logic                                       sram_hold,

  input  logic                                       rd_en,
  input  logic [axil_sram_pkg::SRAM_ADDR_WIDTH-1:0]  rd_addr,
  output axil_sram_pkg::sram_word_t                  rd_data,

  output logic                                       wr_busy
);
  import axil_sram_pkg::*;

  // Adapter to FIFO
  logic                       cmd_valid;
  logic                       cmd_ready;
  logic [WORD_ADDR_WIDTH-1:0] cmd_addr;
  logic [AXIL_DATA_WIDTH-1:0] cmd_data;
  logic [STRB_WIDTH-1:0]      cmd_strb;

  // FIFO to SRAM
  logic                       out_valid;
  logic                       wr_ready;
  logic [WORD_ADDR_WIDTH-1:0] out_addr;
  logic [AXIL_DATA_WIDTH-1:0] out_data;
  logic [STRB_WIDTH-1:0]      out_strb;

  axil_wr_adapter u_adapter (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .cmd_strb  (cmd_strb)
  );

  wr_cmd_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .in_addr   (cmd_addr),
    .in_data   (cmd_data),
    .in_strb   (cmd_strb),
    .out_valid (out_valid),
    .out_ready (wr_ready),
    .out_addr  (out_addr),
    .out_data  (out_data),
    .out_strb  (out_strb),
    .busy      (wr_busy)     // High until the last write lands
  );

  byte_lane_sram u_sram (
    .clk       (clk),
    .hold      (sram_hold),
    .wr_valid  (out_valid),
    .wr_ready  (wr_ready),
    .wr_addr   (out_addr),
    .wr_data   (out_data),
    .wr_strb   (out_strb),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

// File: sim/tb_axil_sram_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axil_sram_top;
  import axil_sram_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam logic [15:0] SEED = 16'd39110;
  localparam int N_WORDS      = 2**SRAM_ADDR_WIDTH;
  localparam int N_FULL       = N_WORDS;
  localparam int N_PART       = 64;
  localparam int N_ALIAS      = 8;
  localparam int BP_WRITES    = FIFO_DEPTH + 2;
  localparam int HOLD_CYCLES  = 20;
  localparam int LONE_GAP     = 6;
  localparam int ALIAS_SHIFT  = SRAM_ADDR_WIDTH + ADDR_LSB;
  localparam int N_WRITES     = N_FULL + N_PART + 2 * N_ALIAS + BP_WRITES + 2;
  localparam int N_READS      = 4 * N_WORDS + N_ALIAS + BP_WRITES + 2;
  localparam int TIMEOUT_NS   = (N_WRITES * 12 + N_READS * 2 + HOLD_CYCLES + 200) * CLK_PERIOD;

  logic                       clk;
  logic                       rst_n;
  logic [AXIL_ADDR_WIDTH-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [AXIL_DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0]      wstrb;
  logic                       wvalid;
  logic                       wready;
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  logic                       sram_hold;
  logic                       rd_en;
  logic [SRAM_ADDR_WIDTH-1:0] rd_addr;
  sram_word_t                 rd_data;
  logic                       wr_busy;

  logic [AXIL_DATA_WIDTH-1:0] model_mem [N_WORDS];
  logic [AXIL_DATA_WIDTH-1:0] snap_mem  [N_WORDS];
  logic [AXIL_DATA_WIDTH-1:0] rd_expect;       // Value the next read must return
  logic [15:0]                lfsr_state;
  logic [AXIL_ADDR_WIDTH-1:0] bp_addr [BP_WRITES];
  logic [AXIL_DATA_WIDTH-1:0] bp_data [BP_WRITES];
  logic [STRB_WIDTH-1:0]      bp_strb [BP_WRITES];
  logic                       bp_done;
  int                         b_count;
  int                         writes_issued;
  int                         value_errs;
  int                         other_errs;
  int                         read_errs;
  int                         bresp_errs;

  axil_sram_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .sram_hold (sram_hold),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .wr_busy   (wr_busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Byte offset dropped, bits above the decoded range ignored
  function automatic logic [SRAM_ADDR_WIDTH-1:0] model_index(
    input logic [AXIL_ADDR_WIDTH-1:0] addr);
    return addr[ADDR_LSB +: SRAM_ADDR_WIDTH];
  endfunction

  function automatic logic [AXIL_DATA_WIDTH-1:0] merge_word(
    input logic [AXIL_DATA_WIDTH-1:0] old_word,
    input logic [AXIL_DATA_WIDTH-1:0] data,
    input logic [STRB_WIDTH-1:0]      strb);
    logic [AXIL_DATA_WIDTH-1:0] r;
    r = old_word;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) begin
        r[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus tasks, all entered on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      $display("error %s: got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic send_aw(input logic [AXIL_ADDR_WIDTH-1:0] addr);
    awaddr  = addr;
    awvalid = 1'b1;
    @(posedge clk);
    while (!awready) @(posedge clk);
    @(negedge clk);
    awvalid = 1'b0;
  endtask

  task automatic send_w(input logic [AXIL_DATA_WIDTH-1:0] data,
                        input logic [STRB_WIDTH-1:0] strb);
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    @(posedge clk);
    while (!wready) @(posedge clk);
    @(negedge clk);
    wvalid = 1'b0;
  endtask

  task automatic issue_write(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                             input logic [AXIL_DATA_WIDTH-1:0] data,
                             input logic [STRB_WIDTH-1:0] strb,
                             input int aw_lag, input int w_lag);
    logic [SRAM_ADDR_WIDTH-1:0] idx;
    idx = model_index(addr);
    model_mem[idx] = merge_word(model_mem[idx], data, strb);
    fork
      begin
        repeat (aw_lag) @(negedge clk);
        send_aw(addr);
      end
      begin
        repeat (w_lag) @(negedge clk);
        send_w(data, strb);
      end
    join
    writes_issued++;
  endtask

  // All accepted writes answered and drained into the SRAM
  task automatic wait_writes_done();
    while (b_count != writes_issued || wr_busy) @(negedge clk);
  endtask

  task automatic check_read(input logic [SRAM_ADDR_WIDTH-1:0] idx,
                            input logic [AXIL_DATA_WIDTH-1:0] word);
    rd_en     = 1'b1;
    rd_addr   = idx;
    rd_expect = word;
    @(negedge clk);
    rd_en = 1'b0;
  endtask

  task automatic check_all_words();
    for (int i = 0; i < N_WORDS; i++) begin
      check_read(SRAM_ADDR_WIDTH'(i), model_mem[i]);
    end
  endtask

  task automatic lone_channel_pair(input bit aw_first);
    logic [AXIL_ADDR_WIDTH-1:0] addr;
    logic [AXIL_DATA_WIDTH-1:0] data;
    logic [SRAM_ADDR_WIDTH-1:0] idx;
    int                         b_start;
    addr    = AXIL_ADDR_WIDTH'(rand_bits(AXIL_ADDR_WIDTH));
    data    = AXIL_DATA_WIDTH'(rand_bits(AXIL_DATA_WIDTH));
    idx     = model_index(addr);
    b_start = b_count;
    if (aw_first) send_aw(addr);
    else send_w(data, '1);
    repeat (LONE_GAP) begin
      @(negedge clk);
      check_value("wr_busy", 16'(wr_busy), 16'h0);
      if (b_count != b_start) begin
        $display("B response issued for a lone %s channel", aw_first ? "AW" : "W");
        other_errs++;
      end
    end
    if (aw_first) send_w(data, '1);
    else send_aw(addr);
    model_mem[idx] = merge_word(model_mem[idx], data, '1);
    writes_issued++;
    wait_writes_done();
    repeat (4) @(negedge clk);
    if (b_count != b_start + 1) begin
      $display("expected one B response for a joined pair, saw %0d", b_count - b_start);
      other_errs++;
    end
    check_read(idx, model_mem[idx]);
  endtask

  ////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : count_b
    if (rst_n && bvalid && bready) begin
      b_count++;
      assert (bresp === 2'b00) else begin
        $display("error bresp: got %h expected %h", bresp, 2'b00);
        bresp_errs++;
      end
    end
  end

  // Read data lands one cycle after rd_en
  always @(posedge clk) begin : compare_reads
    logic [SRAM_ADDR_WIDTH-1:0] addr_s;
    logic [AXIL_DATA_WIDTH-1:0] word_s;
    if (rd_en) begin
      addr_s = rd_addr;
      word_s = rd_expect;
      @(negedge clk);
      assert (rd_data.word === word_s) else begin
        $display("error rd_data at %h: got %h expected %h", addr_s, rd_data.word, word_s);
        read_errs++;
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [AXIL_ADDR_WIDTH-1:0] addr;
    logic [AXIL_ADDR_WIDTH-1:0] addr2;
    logic [SRAM_ADDR_WIDTH-1:0] idx;
    int                         b_start;
    clk           = 1'b0;
    rst_n         = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    sram_hold     = 1'b0;
    rd_en         = 1'b0;
    rd_addr       = '0;
    rd_expect     = '0;
    lfsr_state    = SEED;
    bp_done       = 1'b0;
    b_count       = 0;
    writes_issued = 0;
    value_errs    = 0;
    other_errs    = 0;
    read_errs     = 0;
    bresp_errs    = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("awready", 16'(awready), 16'h0);
    check_value("wready", 16'(wready), 16'h0);
    check_value("bvalid", 16'(bvalid), 16'h0);
    check_value("bresp", 16'(bresp), 16'h0);
    check_value("wr_busy", 16'(wr_busy), 16'h0);
    bready = 1'b1;

    lone_channel_pair(1'b1);
    lone_channel_pair(1'b0);

    // Every word gets a full write, which also sets up the model
    for (int i = 0; i < N_FULL; i++) begin
      addr = AXIL_ADDR_WIDTH'(rand_bits(AXIL_ADDR_WIDTH));
      addr[ADDR_LSB +: SRAM_ADDR_WIDTH] = SRAM_ADDR_WIDTH'(i);
      issue_write(addr, AXIL_DATA_WIDTH'(rand_bits(AXIL_DATA_WIDTH)), '1, 0, 0);
    end
    wait_writes_done();
    check_all_words();

    for (int i = 0; i < N_PART; i++) begin
      issue_write(AXIL_ADDR_WIDTH'(rand_bits(AXIL_ADDR_WIDTH)),
                  AXIL_DATA_WIDTH'(rand_bits(AXIL_DATA_WIDTH)),
                  STRB_WIDTH'(rand_bits(STRB_WIDTH)),
                  int'(rand_bits(2)), int'(rand_bits(2)));
    end
    wait_writes_done();
    check_all_words();

    // Back-pressure
    sram_hold = 1'b1;
    snap_mem  = model_mem;
    b_start   = b_count;
    for (int i = 0; i < BP_WRITES; i++) begin
      bp_addr[i] = AXIL_ADDR_WIDTH'(rand_bits(AXIL_ADDR_WIDTH));
      bp_data[i] = AXIL_DATA_WIDTH'(rand_bits(AXIL_DATA_WIDTH));
      bp_strb[i] = STRB_WIDTH'(rand_bits(STRB_WIDTH));
    end
    fork
      begin
        for (int i = 0; i < BP_WRITES; i++) begin
          issue_write(bp_addr[i], bp_data[i], bp_strb[i], 0, 0);
        end
        bp_done = 1'b1;
      end
    join_none
    repeat (HOLD_CYCLES) @(negedge clk);
    if (bp_done) begin
      $display("all writes were accepted while the SRAM was on hold");
      other_errs++;
    end
    if (awready && wready) begin
      $display("AW and W still accepted with a full command FIFO");
      other_errs++;
    end
    if (b_count - b_start > FIFO_DEPTH) begin
      $display("%0d B responses under hold, more than the FIFO holds", b_count - b_start);
      other_errs++;
    end
    check_value("wr_busy", 16'(wr_busy), 16'h1);
    for (int i = 0; i < BP_WRITES; i++) begin
      idx = model_index(bp_addr[i]);
      check_read(idx, snap_mem[idx]);                // Nothing written yet
    end
    sram_hold = 1'b0;
    while (!bp_done) @(negedge clk);
    wait_writes_done();
    if (b_count - b_start != BP_WRITES) begin
      $display("%0d B responses after hold release, wanted %0d", b_count - b_start, BP_WRITES);
      other_errs++;
    end
    check_all_words();

    // Upper bits and byte offset differ, same word
    for (int k = 0; k < N_ALIAS; k++) begin
      addr  = AXIL_ADDR_WIDTH'(rand_bits(AXIL_ADDR_WIDTH));
      addr2 = addr ^ (AXIL_ADDR_WIDTH'(k + 1) << ALIAS_SHIFT) ^ AXIL_ADDR_WIDTH'(1);
      issue_write(addr, AXIL_DATA_WIDTH'(rand_bits(AXIL_DATA_WIDTH)), '1, 0, 0);
      issue_write(addr2, AXIL_DATA_WIDTH'(rand_bits(AXIL_DATA_WIDTH)),
                  STRB_WIDTH'(rand_bits(STRB_WIDTH)), 0, 0);
      wait_writes_done();
      idx = model_index(addr);
      check_read(idx, model_mem[idx]);
    end
    check_all_words();

    repeat (2) @(negedge clk);
    $display("errors: %0d read, %0d response, %0d value, %0d other",
             read_errs, bresp_errs, value_errs, other_errs);
    if (read_errs == 0 && bresp_errs == 0 && value_errs == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/axil_sram_pkg.sv
source/axil_wr_adapter.sv
source/wr_cmd_fifo.sv
source/byte_lane_sram.sv
source/axil_sram_top.sv
sim/tb_axil_sram_top.sv

// File: Makefile
# Verilator flow for the AXI-Lite SRAM write path

VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_axil_sram_top
RTL_TOP   ?= axil_sram_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# Pass only when the testbench printed the pass message
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
